// File: design/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Base geometry
`define DC_ADDR_W      32
`define DC_WORD_W      32
`define DC_LINE_WORDS  4
`define DC_WAYS        2
`define DC_SETS        16

// Derived widths
`define DC_BYTE_OFF_W  ($clog2(`DC_WORD_W / 8))
`define DC_WORD_OFF_W  ($clog2(`DC_LINE_WORDS))
`define DC_INDEX_W     ($clog2(`DC_SETS))
`define DC_TAG_W       (`DC_ADDR_W - `DC_INDEX_W - `DC_WORD_OFF_W - `DC_BYTE_OFF_W)
`define DC_WAY_W       ($clog2(`DC_WAYS))
`define DC_LINE_W      (`DC_LINE_WORDS * `DC_WORD_W)

`endif

// File: design/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]       addr_t;
    typedef logic [`DC_WORD_W-1:0]       word_t;
    typedef logic [`DC_WORD_W/8-1:0]     be_t;
    typedef logic [`DC_TAG_W-1:0]        tag_t;
    typedef logic [`DC_INDEX_W-1:0]      index_t;
    typedef logic [`DC_WORD_OFF_W-1:0]   offset_t;
    typedef logic [`DC_LINE_W-1:0]       line_t;
    typedef logic [`DC_WAYS-1:0]         way_mask_t;
    typedef logic [`DC_WAY_W-1:0]        way_id_t;

    // Request sequencing in the controller
    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        LOOKUP,
        EVICT,
        REFILL,
        FILL
    } ctrl_state_t;

    // Memory port engine
    typedef enum logic [2:0] {
        B_IDLE,
        B_ADDR_R,
        B_DATA_R,
        B_ADDR_W,
        B_DATA_W,
        B_RESP
    } burst_state_t;

endpackage

// File: design/way_bus_if.sv
`include "dcache_defs.svh"

interface way_bus_if;
    import dcache_pkg::*;

    // Lookup request, results appear the cycle after rd_en
    index_t    rd_index;
    tag_t      rd_tag;
    logic      rd_en;

    // Fill and update port, one mask bit per way
    way_mask_t wr_mask;
    index_t    wr_index;
    tag_t      wr_tag;
    logic      wr_dirty;
    logic      wr_valid;
    line_t     wr_line;

    // Per-way read results
    logic      hit   [`DC_WAYS];
    logic      valid [`DC_WAYS];
    logic      dirty [`DC_WAYS];
    tag_t      tag   [`DC_WAYS];
    line_t     line  [`DC_WAYS];

    // Selector results
    logic      any_hit;
    line_t     hit_line;
    way_id_t   hit_way;
    way_id_t   victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    line_t     victim_line;
    logic      victim_next;

    modport ctrl (
        output rd_index, rd_tag, rd_en,
        output wr_mask, wr_index, wr_tag, wr_dirty, wr_valid, wr_line,
        output victim_next,
        input  any_hit, hit_line, hit_way,
        input  victim_way, victim_dirty, victim_tag, victim_line
    );

    modport way (
        input  rd_index, rd_tag, rd_en,
        input  wr_mask, wr_index, wr_tag, wr_dirty, wr_valid, wr_line,
        output hit, valid, dirty, tag, line
    );

    modport select (
        input  hit, valid, dirty, tag, line, victim_next,
        output any_hit, hit_line, hit_way,
        output victim_way, victim_dirty, victim_tag, victim_line
    );

endinterface

// File: design/burst_if.sv
interface burst_if;
    import dcache_pkg::*;

    // One start pulse per transfer, never before the previous done
    logic  start_read;
    logic  start_write;
    addr_t addr;
    line_t wline;

    // rline is complete on the done of a read
    line_t rline;
    logic  done;

    modport ctrl (
        output start_read,
        output start_write,
        output addr,
        output wline,
        input  rline,
        input  done
    );

    modport engine (
        input  start_read,
        input  start_write,
        input  addr,
        input  wline,
        output rline,
        output done
    );

endinterface

// File: design/cache_way.sv
`include "dcache_defs.svh"

module cache_way #(
    parameter int WAY_ID = 0
) (
    input  logic    clk,
    input  logic    rst,
    way_bus_if.way  bus
);
    import dcache_pkg::*;

    tag_t  tag_mem   [`DC_SETS];
    logic  valid_mem [`DC_SETS];
    logic  dirty_mem [`DC_SETS];
    line_t line_mem  [`DC_SETS];

    tag_t  tag_q;
    logic  valid_q;
    logic  dirty_q;
    line_t line_q;

    // Update port, also used by the reset sweep
    always_ff @(posedge clk) begin
        if (bus.wr_mask[WAY_ID]) begin
            tag_mem[bus.wr_index]   <= bus.wr_tag;
            valid_mem[bus.wr_index] <= bus.wr_valid;
            dirty_mem[bus.wr_index] <= bus.wr_dirty;
            line_mem[bus.wr_index]  <= bus.wr_line;
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            tag_q   <= tag_mem[bus.rd_index];
            dirty_q <= dirty_mem[bus.rd_index];
            line_q  <= line_mem[bus.rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (bus.rd_en) begin
            valid_q <= valid_mem[bus.rd_index];
        end
    end

    assign bus.hit[WAY_ID]   = valid_q && (tag_q == bus.rd_tag);
    assign bus.valid[WAY_ID] = valid_q;
    assign bus.dirty[WAY_ID] = dirty_q;
    assign bus.tag[WAY_ID]   = tag_q;
    assign bus.line[WAY_ID]  = line_q;

endmodule

// File: design/way_select.sv
`include "dcache_defs.svh"

module way_select (
    input  logic       clk,
    input  logic       rst,
    way_bus_if.select  bus
);
    import dcache_pkg::*;

    logic [7:0] lfsr;
    way_id_t    vway;

    // Stepped once per miss, taps at 8, 6, 5, 4
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'hff;
        end else if (bus.victim_next) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign vway = lfsr[`DC_WAY_W-1:0];

    // At most one way hits, so OR is enough for the line
    always_comb begin
        bus.any_hit  = 1'b0;
        bus.hit_line = '0;
        bus.hit_way  = '0;
        for (int i = 0; i < `DC_WAYS; i++) begin
            if (bus.hit[i]) begin
                bus.any_hit  = 1'b1;
                bus.hit_line = bus.hit_line | bus.line[i];
                bus.hit_way  = way_id_t'(i);
            end
        end
    end

    // Victim readout, an invalid way never needs write-back
    assign bus.victim_way   = vway;
    assign bus.victim_dirty = bus.valid[vway] && bus.dirty[vway];
    assign bus.victim_tag   = bus.tag[vway];
    assign bus.victim_line  = bus.line[vway];

endmodule

// File: design/mem_burst.sv
`include "dcache_defs.svh"

module mem_burst (
    input  logic               clk,
    input  logic               rst,
    burst_if.engine            bus,
    output dcache_pkg::addr_t  mem_araddr,
    output logic               mem_arvalid,
    input  logic               mem_arready,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic               mem_rvalid,
    input  logic               mem_rlast,
    output logic               mem_rready,
    output dcache_pkg::addr_t  mem_awaddr,
    output logic               mem_awvalid,
    input  logic               mem_awready,
    output dcache_pkg::word_t  mem_wdata,
    output logic               mem_wvalid,
    output logic               mem_wlast,
    input  logic               mem_wready,
    input  logic               mem_bvalid
);
    import dcache_pkg::*;

    localparam offset_t LAST_BEAT = offset_t'(`DC_LINE_WORDS - 1);

    burst_state_t state;
    offset_t      beat;
    addr_t        addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= B_IDLE;
            beat     <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            case (state)
                B_IDLE: begin
                    beat <= '0;
                    if (bus.start_read) begin
                        state <= B_ADDR_R;
                    end else if (bus.start_write) begin
                        state <= B_ADDR_W;
                    end
                end
                B_ADDR_R: if (mem_arready) state <= B_DATA_R;
                B_DATA_R: begin
                    if (mem_rvalid) begin
                        beat <= beat + 1'b1;
                        // Close on rlast or the final counted beat
                        if (beat == LAST_BEAT || mem_rlast) begin
                            state    <= B_IDLE;
                            bus.done <= 1'b1;
                        end
                    end
                end
                B_ADDR_W: if (mem_awready) state <= B_DATA_W;
                B_DATA_W: begin
                    if (mem_wready) begin
                        beat <= beat + 1'b1;
                        if (beat == LAST_BEAT) begin
                            state <= B_RESP;
                        end
                    end
                end
                B_RESP: begin
                    if (mem_bvalid) begin
                        state    <= B_IDLE;
                        bus.done <= 1'b1;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // Address latch and read line assembly
    always_ff @(posedge clk) begin
        if (state == B_IDLE && (bus.start_read || bus.start_write)) begin
            addr_q <= bus.addr;
        end
        if (state == B_DATA_R && mem_rvalid) begin
            bus.rline[beat*`DC_WORD_W +: `DC_WORD_W] <= mem_rdata;
        end
    end

    assign mem_arvalid = (state == B_ADDR_R);
    assign mem_araddr  = addr_q;
    assign mem_rready  = (state == B_DATA_R);
    assign mem_awvalid = (state == B_ADDR_W);
    assign mem_awaddr  = addr_q;
    assign mem_wvalid  = (state == B_DATA_W);
    assign mem_wdata   = bus.wline[beat*`DC_WORD_W +: `DC_WORD_W];
    assign mem_wlast   = (state == B_DATA_W) && (beat == LAST_BEAT);

endmodule

// File: design/dcache_ctrl.sv
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req,
    input  logic               cpu_write,
    input  dcache_pkg::addr_t  cpu_addr,
    input  dcache_pkg::word_t  cpu_wdata,
    input  dcache_pkg::be_t    cpu_be,
    output logic               cpu_stall,
    output dcache_pkg::word_t  cpu_rdata,
    output logic               cpu_rvalid,
    way_bus_if.ctrl            wbus,
    burst_if.ctrl              bbus
);
    import dcache_pkg::*;

    localparam int LINE_OFF_W = `DC_WORD_OFF_W + `DC_BYTE_OFF_W;

    function automatic word_t line_word(line_t l, offset_t off);
        return l[off*`DC_WORD_W +: `DC_WORD_W];
    endfunction

    // Byte-enable merge of one word into a line
    function automatic line_t line_merge(line_t l, offset_t off, word_t w, be_t be);
        line_t res;
        word_t old_w;
        res = l;
        old_w = line_word(l, off);
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (be[b]) begin
                old_w[8*b +: 8] = w[8*b +: 8];
            end
        end
        res[off*`DC_WORD_W +: `DC_WORD_W] = old_w;
        return res;
    endfunction

    ctrl_state_t state;
    index_t      sweep_idx;
    logic        looked;
    logic        start_rd_q;
    logic        start_wr_q;

    // Captured request
    addr_t   req_addr;
    logic    req_write;
    word_t   req_wdata;
    be_t     req_be;
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_off;

    // Victim, then refill data
    way_id_t vict_way_q;
    tag_t    vict_tag_q;
    line_t   line_q;

    logic    decide;

    assign req_off   = req_addr[`DC_BYTE_OFF_W +: `DC_WORD_OFF_W];
    assign req_index = req_addr[LINE_OFF_W +: `DC_INDEX_W];
    assign req_tag   = req_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    assign cpu_stall = (state != IDLE);

    // Way outputs are valid on the second LOOKUP cycle
    assign decide = (state == LOOKUP) && looked;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SWEEP;
            sweep_idx  <= '0;
            looked     <= 1'b0;
            start_rd_q <= 1'b0;
            start_wr_q <= 1'b0;
            cpu_rvalid <= 1'b0;
        end else begin
            start_rd_q <= 1'b0;
            start_wr_q <= 1'b0;
            cpu_rvalid <= 1'b0;
            case (state)
                SWEEP: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == index_t'(`DC_SETS - 1)) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    looked <= 1'b0;
                    if (cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    looked <= 1'b1;
                    if (looked) begin
                        if (wbus.any_hit) begin
                            state      <= IDLE;
                            cpu_rvalid <= !req_write;
                        end else if (wbus.victim_dirty) begin
                            state      <= EVICT;
                            start_wr_q <= 1'b1;
                        end else begin
                            state      <= REFILL;
                            start_rd_q <= 1'b1;
                        end
                    end
                end
                EVICT: begin
                    if (bbus.done) begin
                        state      <= REFILL;
                        start_rd_q <= 1'b1;
                    end
                end
                REFILL: begin
                    if (bbus.done) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    state      <= IDLE;
                    cpu_rvalid <= !req_write;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req) begin
            req_addr  <= cpu_addr;
            req_write <= cpu_write;
            req_wdata <= cpu_wdata;
            req_be    <= cpu_be;
        end
        if (decide) begin
            cpu_rdata  <= line_word(wbus.hit_line, req_off);
            vict_way_q <= wbus.victim_way;
            vict_tag_q <= wbus.victim_tag;
            line_q     <= wbus.victim_line;
        end
        if (state == REFILL && bbus.done) begin
            line_q <= bbus.rline;
        end
        if (state == FILL) begin
            cpu_rdata <= line_word(line_q, req_off);
        end
    end

    // Lookup port
    assign wbus.rd_en       = (state == LOOKUP) && !looked;
    assign wbus.rd_index    = req_index;
    assign wbus.rd_tag      = req_tag;
    assign wbus.victim_next = decide && !wbus.any_hit;

    // Sweep, write hit and refill all share the fill port
    always_comb begin
        wbus.wr_mask  = '0;
        wbus.wr_index = req_index;
        wbus.wr_tag   = req_tag;
        wbus.wr_valid = 1'b1;
        wbus.wr_dirty = req_write;
        wbus.wr_line  = line_merge(line_q, req_off, req_wdata, req_write ? req_be : '0);
        case (state)
            SWEEP: begin
                wbus.wr_mask  = '1;
                wbus.wr_index = sweep_idx;
                wbus.wr_valid = 1'b0;
                wbus.wr_dirty = 1'b0;
            end
            LOOKUP: begin
                if (decide && wbus.any_hit && req_write) begin
                    wbus.wr_mask = way_mask_t'(1) << wbus.hit_way;
                    wbus.wr_line = line_merge(wbus.hit_line, req_off, req_wdata, req_be);
                end
            end
            FILL: begin
                wbus.wr_mask = way_mask_t'(1) << vict_way_q;
            end
            default: begin
                wbus.wr_mask = '0;
            end
        endcase
    end

    // Victim line goes out in EVICT, the missing line comes in during REFILL
    assign bbus.start_read  = start_rd_q;
    assign bbus.start_write = start_wr_q;
    assign bbus.wline       = line_q;
    assign bbus.addr = (state == EVICT) ? {vict_tag_q, req_index, {LINE_OFF_W{1'b0}}}
                                        : {req_tag, req_index, {LINE_OFF_W{1'b0}}};

endmodule

// File: design/dcache_top.sv
`include "dcache_defs.svh"

module dcache_top (
    input  logic               clk,
    input  logic               rst,

    // CPU side
    input  logic               cpu_req,
    input  logic               cpu_write,
    input  dcache_pkg::addr_t  cpu_addr,
    input  dcache_pkg::word_t  cpu_wdata,
    input  dcache_pkg::be_t    cpu_be,
    output logic               cpu_stall,
    output dcache_pkg::word_t  cpu_rdata,
    output logic               cpu_rvalid,

    // Memory side
    output dcache_pkg::addr_t  mem_araddr,
    output logic               mem_arvalid,
    input  logic               mem_arready,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic               mem_rvalid,
    input  logic               mem_rlast,
    output logic               mem_rready,
    output dcache_pkg::addr_t  mem_awaddr,
    output logic               mem_awvalid,
    input  logic               mem_awready,
    output dcache_pkg::word_t  mem_wdata,
    output logic               mem_wvalid,
    output logic               mem_wlast,
    input  logic               mem_wready,
    input  logic               mem_bvalid
);

    way_bus_if wbus ();
    burst_if   bbus ();

    dcache_ctrl u_ctrl (
        .clk,
        .rst,
        .cpu_req,
        .cpu_write,
        .cpu_addr,
        .cpu_wdata,
        .cpu_be,
        .cpu_stall,
        .cpu_rdata,
        .cpu_rvalid,
        .wbus (wbus.ctrl),
        .bbus (bbus.ctrl)
    );

    for (genvar i = 0; i < `DC_WAYS; i++) begin : gen_way
        cache_way #(
            .WAY_ID (i)
        ) u_way (
            .clk,
            .rst,
            .bus (wbus.way)
        );
    end

    way_select u_sel (
        .clk,
        .rst,
        .bus (wbus.select)
    );

    mem_burst u_burst (
        .clk,
        .rst,
        .bus (bbus.engine),
        .mem_araddr,
        .mem_arvalid,
        .mem_arready,
        .mem_rdata,
        .mem_rvalid,
        .mem_rlast,
        .mem_rready,
        .mem_awaddr,
        .mem_awvalid,
        .mem_awready,
        .mem_wdata,
        .mem_wvalid,
        .mem_wlast,
        .mem_wready,
        .mem_bvalid
    );

endmodule

// File: sim/dcache_asserts.sv
module dcache_asserts (
    input logic               clk,
    input logic               rst,
    input logic               cpu_req,
    input logic               cpu_write,
    input logic               cpu_stall,
    input logic               cpu_rvalid,
    input logic               mem_arvalid,
    input logic               mem_arready,
    input dcache_pkg::addr_t  mem_araddr,
    input logic               mem_awvalid,
    input logic               mem_awready,
    input dcache_pkg::addr_t  mem_awaddr,
    input logic               mem_wvalid,
    input logic               mem_wready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic read_open;

    // Set by an accepted read, cleared by its data
    always_ff @(posedge clk) begin
        if (rst) begin
            read_open <= 1'b0;
        end else if (cpu_req && !cpu_stall) begin
            read_open <= !cpu_write;
        end else if (cpu_rvalid) begin
            read_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("read address valid dropped or changed before its handshake");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr))
        else $error("write address valid dropped or changed before its handshake");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wvalid && !mem_wready |=> mem_wvalid)
        else $error("write data valid dropped before its handshake");

    rvalid_needs_read: assert property (@(posedge clk) disable iff (rst)
        cpu_rvalid |-> read_open)
        else $error("cpu_rvalid without an open read");

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .cpu_req     (cpu_req),
    .cpu_write   (cpu_write),
    .cpu_stall   (cpu_stall),
    .cpu_rvalid  (cpu_rvalid),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_araddr  (mem_araddr),
    .mem_awvalid (mem_awvalid),
    .mem_awready (mem_awready),
    .mem_awaddr  (mem_awaddr),
    .mem_wvalid  (mem_wvalid),
    .mem_wready  (mem_wready)
);

// File: sim/dcache_tb.sv
`include "dcache_defs.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int          N_OPS     = 2000;
    localparam int          PERIOD    = 40;
    localparam int          DRIVE_DLY = 2;
    localparam int          BEATS     = `DC_LINE_WORDS;
    localparam logic [31:0] SEED      = 32'h8734a6ba;

    logic  clk = 1'b0;
    logic  rst;
    logic  cpu_req;
    logic  cpu_write;
    addr_t cpu_addr;
    word_t cpu_wdata;
    be_t   cpu_be;
    logic  cpu_stall;
    word_t cpu_rdata;
    logic  cpu_rvalid;

    addr_t mem_araddr;
    logic  mem_arvalid;
    logic  mem_arready;
    word_t mem_rdata;
    logic  mem_rvalid;
    logic  mem_rlast;
    logic  mem_rready;
    addr_t mem_awaddr;
    logic  mem_awvalid;
    logic  mem_awready;
    word_t mem_wdata;
    logic  mem_wvalid;
    logic  mem_wlast;
    logic  mem_wready;
    logic  mem_bvalid;

    // Reference contents and external memory, keyed by word address
    word_t ref_mem [addr_t];
    word_t ext_mem [addr_t];

    logic [31:0] cpu_rng = SEED;
    logic [31:0] mem_rng = SEED ^ 32'h0f0f_1234;

    int data_errs   = 0;
    int mem_errs    = 0;
    int timing_errs = 0;
    int ar_count    = 0;
    int aw_count    = 0;

    // Memory model state
    logic  rd_active = 1'b0;
    addr_t rd_addr;
    int    rd_beat = 0;
    int    r_gap   = 0;
    logic  wr_active = 1'b0;
    addr_t wr_addr;
    int    wr_beat = 0;
    int    ar_wait = 0;
    int    aw_wait = 0;
    int    w_wait  = 0;

    dcache_top dut0 (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] cpu_rand();
        cpu_rng = xorshift32(cpu_rng);
        return cpu_rng;
    endfunction

    function automatic int mem_delay();
        mem_rng = xorshift32(mem_rng);
        return int'(mem_rng & 32'h3);
    endfunction

    // Power-up contents, every address bit matters
    function automatic word_t fill_word(addr_t a);
        return (a ^ 32'h5ac3_96e1) + {a[7:0], a[31:8]};
    endfunction

    function automatic word_t ref_word(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (ext_mem.exists(a)) begin
            return ext_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // 3 tags over 4 sets keeps both ways busy
    function automatic addr_t make_addr(logic [31:0] r);
        tag_t    t;
        index_t  idx;
        offset_t off;
        case (int'(r[19:16]) % 3)
            0:       t = 24'h00_0123;
            1:       t = 24'h0a_5a5a;
            default: t = 24'h3c_0ff0;
        endcase
        case (r[21:20])
            2'd0:    idx = 4'd1;
            2'd1:    idx = 4'd6;
            2'd2:    idx = 4'd11;
            default: idx = 4'd14;
        endcase
        off = r[23:22];
        return {t, idx, off, 2'b00};
    endfunction

    task automatic check_reset_sweep();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cpu_stall && cycles < 4 * `DC_SETS) begin
            if (cpu_rvalid || mem_arvalid || mem_awvalid) begin
                $display("** Error: {cpu_rvalid, mem_arvalid, mem_awvalid} in sweep = %h, %s",
                         {cpu_rvalid, mem_arvalid, mem_awvalid}, "expected 0");
                timing_errs++;
            end
            cycles++;
            @(negedge clk);
        end
        if (cycles != `DC_SETS) begin
            $display("** Error: cpu_stall high cycles = %0h, expected %0h", cycles, `DC_SETS);
            timing_errs++;
        end
    endtask

    task automatic do_request(input logic wr, input addr_t a, input word_t wd, input be_t be,
                              input logic fast);
        word_t exp;
        int    edges;
        int    ar_before;
        @(posedge clk);
        #DRIVE_DLY;
        cpu_req   = 1'b1;
        cpu_write = wr;
        cpu_addr  = a;
        cpu_wdata = wd;
        cpu_be    = be;
        @(negedge clk);
        while (cpu_stall) begin
            @(negedge clk);
        end
        // Accepted at the coming edge
        exp = ref_word(a);
        if (wr) begin
            ref_mem[a] = merge_bytes(exp, wd, be);
        end
        ar_before = ar_count;
        @(posedge clk);
        #DRIVE_DLY;
        cpu_req = 1'b0;
        edges = 0;
        @(negedge clk);
        while (cpu_stall) begin
            edges++;
            @(negedge clk);
        end
        if (!wr) begin
            if (!cpu_rvalid) begin
                $display("** Error: cpu_rvalid after read of %h = %h, expected %h",
                         a, cpu_rvalid, 1'b1);
                data_errs++;
            end else if (cpu_rdata != exp) begin
                $display("** Error: cpu_rdata at %h = %h, expected %h", a, cpu_rdata, exp);
                data_errs++;
            end
        end else if (cpu_rvalid) begin
            $display("** Error: cpu_rvalid after write to %h = %h, expected %h", a, 1, 0);
            data_errs++;
        end
        if (fast) begin
            if (edges != 2) begin
                $display("** Error: cpu_stall cycles after accepting %h = %h, expected %h",
                         a, edges, 2);
                timing_errs++;
            end
            if (ar_count != ar_before) begin
                $display("Read hit at %h started a memory read burst", a);
                timing_errs++;
            end
        end
    endtask

    // Memory model, samples at the falling edge and answers after the rising edge
    initial begin : memory_model
        logic  ar_fire;
        logic  r_fire;
        logic  aw_fire;
        logic  w_fire;
        logic  ar_seen;
        logic  aw_seen;
        logic  w_seen;
        logic  wlast_s;
        addr_t araddr_s;
        addr_t awaddr_s;
        addr_t wa;
        word_t wdata_s;
        word_t exp;
        mem_arready = 1'b1;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rlast   = 1'b0;
        mem_awready = 1'b1;
        mem_wready  = 1'b1;
        mem_bvalid  = 1'b0;
        forever begin
            @(negedge clk);
            ar_fire  = mem_arvalid && mem_arready;
            r_fire   = mem_rvalid && mem_rready;
            aw_fire  = mem_awvalid && mem_awready;
            w_fire   = mem_wvalid && mem_wready;
            ar_seen  = mem_arvalid;
            aw_seen  = mem_awvalid;
            w_seen   = mem_wvalid;
            araddr_s = mem_araddr;
            awaddr_s = mem_awaddr;
            wdata_s  = mem_wdata;
            wlast_s  = mem_wlast;
            @(posedge clk);
            #DRIVE_DLY;
            mem_bvalid = 1'b0;

            if (ar_fire) begin
                ar_count++;
                if (rd_active) begin
                    $display("Read address accepted while a read burst was open");
                    mem_errs++;
                end
                if (araddr_s[3:0] != 4'h0) begin
                    $display("** Error: mem_araddr = %h, expected %h", araddr_s,
                             {araddr_s[31:4], 4'h0});
                    mem_errs++;
                end
                rd_active = 1'b1;
                rd_addr   = {araddr_s[31:4], 4'h0};
                rd_beat   = 0;
                r_gap     = mem_delay();
                ar_wait   = mem_delay();
            end else if (ar_seen && ar_wait > 0) begin
                ar_wait--;
            end
            mem_arready = (ar_wait == 0);

            if (r_fire) begin
                rd_beat++;
                if (rd_beat == BEATS) begin
                    rd_active = 1'b0;
                end
                r_gap = mem_delay();
            end
            if (rd_active && r_gap == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = mem_word(rd_addr + addr_t'(4 * rd_beat));
                mem_rlast  = (rd_beat == BEATS - 1);
            end else begin
                mem_rvalid = 1'b0;
                mem_rlast  = 1'b0;
                if (rd_active && r_gap > 0) begin
                    r_gap--;
                end
            end

            if (aw_fire) begin
                aw_count++;
                if (wr_active) begin
                    $display("Write address accepted while a write burst was open");
                    mem_errs++;
                end
                if (awaddr_s[3:0] != 4'h0) begin
                    $display("** Error: mem_awaddr = %h, expected %h", awaddr_s,
                             {awaddr_s[31:4], 4'h0});
                    mem_errs++;
                end
                wr_active = 1'b1;
                wr_addr   = {awaddr_s[31:4], 4'h0};
                wr_beat   = 0;
                aw_wait   = mem_delay();
            end else if (aw_seen && aw_wait > 0) begin
                aw_wait--;
            end
            mem_awready = (aw_wait == 0);

            if (w_fire) begin
                if (!wr_active) begin
                    $display("Write beat accepted outside a write burst");
                    mem_errs++;
                end else begin
                    wa  = wr_addr + addr_t'(4 * wr_beat);
                    exp = ref_word(wa);
                    if (wdata_s != exp) begin
                        $display("** Error: mem_wdata at %h = %h, expected %h", wa, wdata_s, exp);
                        mem_errs++;
                    end
                    if (wlast_s != (wr_beat == BEATS - 1)) begin
                        $display("** Error: mem_wlast on beat %h = %h, expected %h", wr_beat,
                                 wlast_s, (wr_beat == BEATS - 1));
                        mem_errs++;
                    end
                    ext_mem[wa] = wdata_s;
                    wr_beat++;
                    if (wr_beat == BEATS) begin
                        wr_active  = 1'b0;
                        mem_bvalid = 1'b1;
                    end
                end
                w_wait = mem_delay();
            end else if (w_seen && w_wait > 0) begin
                w_wait--;
            end
            mem_wready = (w_wait == 0);
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        addr_t       a;
        addr_t       prev_addr;
        logic        prev_read;
        logic        wr;
        be_t         be;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_be    = '0;
        prev_addr = '0;
        prev_read = 1'b0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_reset_sweep();

        for (int n = 0; n < N_OPS; n++) begin
            r  = cpu_rand();
            wr = r[0];
            be = r[7:4];
            if (be == '0) begin
                be = '1;
            end
            // Often reuse the previous line to hit
            if (r[9:8] == 2'b00 && n > 0) begin
                a = {prev_addr[31:4], r[23:22], 2'b00};
            end else begin
                a = make_addr(r);
            end
            do_request(wr, a, cpu_rand(), be,
                       !wr && prev_read && (a[31:4] == prev_addr[31:4]));
            prev_read = !wr;
            prev_addr = a;
        end

        repeat (4) @(posedge clk);
        if (rd_active || wr_active) begin
            $display("A memory burst was left unfinished");
            mem_errs++;
        end
        $display("Errors: data %0d, memory %0d, timing %0d (%0d reads, %0d write-backs)",
                 data_errs, mem_errs, timing_errs, ar_count, aw_count);
        if (data_errs + mem_errs + timing_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Worst miss fits well inside 60 cycles
    initial begin : watchdog
        #(N_OPS * 60 * PERIOD);
        $display("Timeout: the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: all.f
+incdir+design
design/dcache_pkg.sv
design/way_bus_if.sv
design/burst_if.sv
design/cache_way.sv
design/way_select.sv
design/mem_burst.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/dcache_asserts.sv
sim/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module dcache_tb -o dcache_sim

out=$(./obj_dir/dcache_sim) || true
echo "$out"

if echo "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
exit 1
